// ==== hw/pmp_check_macros.svh ====
`ifndef PMP_CHECK_MACROS_SVH
`define PMP_CHECK_MACROS_SVH

// Region count and widths
`define PMP_NUM_REGIONS 4
`define XLEN            32
`define PMP_CFG_W       8

// PMP CSR address window, cfg0 first
`define CSR_PMPCFG0     12'h3A0
`define CSR_PMP_LAST    12'h3EF

// Instruction fields
`define OPC_SYSTEM      7'b1110011
`define F3_CSRRW        3'b001

// Exception causes as reported on retirement
`define EXC_INSTR_ACC   6'd1
`define EXC_ILL_INSTR   6'd2
`define EXC_LOAD_ACC    6'd5
`define EXC_STORE_ACC   6'd7

// Privilege codes
`define PRIV_U          2'b00
`define PRIV_M          2'b11

`endif

// ==== hw/pmp_check_pkg.sv ====
`include "pmp_check_macros.svh"

package pmp_check_pkg;

  // Address matching mode of one region
  typedef enum logic [1:0] {
    OFF   = 2'd0,
    TOR   = 2'd1,
    NA4   = 2'd2,
    NAPOT = 2'd3
  } pmp_mode_e;

  typedef enum logic [1:0] {
    EXEC  = 2'd0,
    READ  = 2'd1,
    WRITE = 2'd2
  } pmp_acc_e;

  // One pmpcfg byte, lock in the top bit
  typedef struct packed {
    logic      lock;
    logic [1:0] zero;
    pmp_mode_e mode;
    logic      x;
    logic      w;
    logic      r;
  } pmpcfg_t;

  typedef struct packed {
    logic       trap;
    logic       exception;
    logic [5:0] cause;
  } trap_t;

  // Retirement record from the core
  typedef struct packed {
    logic             valid;
    logic [31:0]      insn;
    logic [1:0]       mode;
    trap_t            trap;
    logic [`XLEN-1:0] rs1_rdata;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] mem_addr;
    logic [3:0]       mem_rmask;
    logic [3:0]       mem_wmask;
  } retire_t;

  // PMP CSR values seen before the retirement
  typedef struct packed {
    pmpcfg_t [`PMP_NUM_REGIONS-1:0]         cfg;
    logic [`PMP_NUM_REGIONS-1:0][`XLEN-1:0] addr;
    logic                                   mprv;
    logic [1:0]                             mpp;
  } pmp_state_t;

  // Reported pmpcfg0 write, one byte per region
  typedef struct packed {
    logic [3:0][`PMP_CFG_W-1:0] wdata;
    logic [3:0][`PMP_CFG_W-1:0] wmask;
  } cfg_write_t;

  typedef struct packed {
    logic is_pmp_csr;
    logic is_cfg0_csrrw;
    logic spare;
  } csr_info_t;

  typedef struct packed {
    logic valid;
    logic csr_priv;
    logic exec;
    logic load;
    logic store;
    logic cfg;
  } verdict_t;

endpackage

// ==== hw/pmp_retire_decode.sv ====
`timescale 1ns/1ps
`include "pmp_check_macros.svh"

module pmp_retire_decode (
  input  pmp_check_pkg::retire_t    retire_i,
  input  pmp_check_pkg::pmp_state_t pmp_state_i,
  output pmp_check_pkg::csr_info_t  csr_info_o,
  output logic [1:0]                data_priv_o,
  output pmp_check_pkg::pmp_acc_e   data_acc_o
);

  logic [11:0] csr_addr;
  logic [2:0]  funct3;
  logic        is_csr;
  logic        in_pmp_window;

  assign csr_addr = retire_i.insn[31:20];
  assign funct3   = retire_i.insn[14:12];

  // funct3 0 is ecall/ebreak/xret, 4 is reserved
  assign is_csr = (retire_i.insn[6:0] == `OPC_SYSTEM) &&
                  (funct3 != 3'b000) &&
                  (funct3 != 3'b100);

  assign in_pmp_window = (csr_addr >= `CSR_PMPCFG0) &&
                         (csr_addr <= `CSR_PMP_LAST);

  assign csr_info_o.is_pmp_csr = is_csr && in_pmp_window;

  // Only a csrrw that completed has a write worth checking
  assign csr_info_o.is_cfg0_csrrw = is_csr &&
                                    (funct3 == `F3_CSRRW) &&
                                    (csr_addr == `CSR_PMPCFG0) &&
                                    !retire_i.trap.trap;

  assign csr_info_o.spare = 1'b0;

  // Loads and stores act as mstatus.MPP when MPRV is set
  assign data_priv_o = pmp_state_i.mprv ? pmp_state_i.mpp : retire_i.mode;

  assign data_acc_o = (|retire_i.mem_wmask) ? pmp_check_pkg::WRITE :
                                              pmp_check_pkg::READ;

endmodule

// ==== hw/pmp_region_match.sv ====
`timescale 1ns/1ps
`include "pmp_check_macros.svh"

module pmp_region_match (
  input  pmp_check_pkg::pmp_state_t pmp_state_i,
  input  logic [`XLEN-1:0]          addr_i,
  input  logic [1:0]                priv_i,
  input  pmp_check_pkg::pmp_acc_e   acc_i,
  output logic                      allowed_o
);

  // Word address lines up with the pmpaddr encoding
  logic [`XLEN-1:0]            word_addr;
  logic [`PMP_NUM_REGIONS-1:0] region_hit;
  logic [`PMP_NUM_REGIONS-1:0] region_allow;

  assign word_addr = {2'b00, addr_i[`XLEN-1:2]};

  for (genvar i = 0; i < `PMP_NUM_REGIONS; i++) begin : gen_region
    logic [`XLEN-1:0] tor_lo;
    logic [`XLEN-1:0] napot_mask;
    logic             tor_hit;
    logic             na4_hit;
    logic             napot_hit;
    logic             perm;

    // Region 0 in TOR mode starts at address zero
    if (i == 0) begin : gen_base
      assign tor_lo = '0;
    end else begin : gen_prev
      assign tor_lo = pmp_state_i.addr[i-1];
    end

    // Trailing ones plus the next bit are don't-care in NAPOT
    assign napot_mask = ~(pmp_state_i.addr[i] ^ (pmp_state_i.addr[i] + 1'b1));

    assign tor_hit   = (word_addr >= tor_lo) && (word_addr < pmp_state_i.addr[i]);
    assign na4_hit   = (word_addr == pmp_state_i.addr[i]);
    assign napot_hit = ((word_addr ^ pmp_state_i.addr[i]) & napot_mask) == '0;

    assign region_hit[i] =
      (pmp_state_i.cfg[i].mode == pmp_check_pkg::TOR)   ? tor_hit   :
      (pmp_state_i.cfg[i].mode == pmp_check_pkg::NA4)   ? na4_hit   :
      (pmp_state_i.cfg[i].mode == pmp_check_pkg::NAPOT) ? napot_hit :
      1'b0;

    assign perm =
      (acc_i == pmp_check_pkg::READ)  ? pmp_state_i.cfg[i].r :
      (acc_i == pmp_check_pkg::WRITE) ? pmp_state_i.cfg[i].w :
      (acc_i == pmp_check_pkg::EXEC)  ? pmp_state_i.cfg[i].x :
      1'b0;

    // M-mode bypasses unlocked regions
    assign region_allow[i] = ((priv_i == `PRIV_M) && !pmp_state_i.cfg[i].lock) || perm;
  end

  // Walk from the top so the lowest matching region is applied last
  always_comb begin
    allowed_o = (priv_i == `PRIV_M);
    for (int i = `PMP_NUM_REGIONS - 1; i >= 0; i--) begin
      if (region_hit[i]) begin
        allowed_o = region_allow[i];
      end
    end
  end

endmodule

// ==== hw/pmp_cfg_legalizer.sv ====
`timescale 1ns/1ps
`include "pmp_check_macros.svh"

module pmp_cfg_legalizer (
  input  pmp_check_pkg::pmp_state_t pmp_state_i,
  input  logic [`XLEN-1:0]          rs1_rdata_i,
  input  pmp_check_pkg::cfg_write_t cfg_write_i,
  output logic                      cfg_mismatch_o
);

  logic [`PMP_NUM_REGIONS-1:0] byte_mismatch;

  for (genvar i = 0; i < `PMP_NUM_REGIONS; i++) begin : gen_cfg_byte
    pmp_check_pkg::pmpcfg_t attempt;
    pmp_check_pkg::pmpcfg_t old_cfg;
    pmp_check_pkg::pmpcfg_t legal;

    assign attempt = pmp_check_pkg::pmpcfg_t'(rs1_rdata_i[i*`PMP_CFG_W +: `PMP_CFG_W]);
    assign old_cfg = pmp_state_i.cfg[i];

    always_comb begin
      legal = attempt;
      // W without R is reserved, permissions stay as they were
      if (attempt.w && !attempt.r) begin
        legal.x = old_cfg.x;
        legal.w = old_cfg.w;
        legal.r = old_cfg.r;
      end
      // Locked entry ignores the write
      if (old_cfg.lock) begin
        legal = old_cfg;
      end
      legal.zero = 2'b00;
    end

    // The whole byte must be written with the legal value
    assign byte_mismatch[i] =
      (cfg_write_i.wmask[i] != {`PMP_CFG_W{1'b1}}) ||
      (cfg_write_i.wdata[i] != legal);
  end

  assign cfg_mismatch_o = |byte_mismatch;

endmodule

// ==== hw/pmp_trap_checker.sv ====
`timescale 1ns/1ps
`include "pmp_check_macros.svh"

module pmp_trap_checker (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  pmp_check_pkg::retire_t    retire_i,
  input  pmp_check_pkg::csr_info_t  csr_info_i,
  input  logic                      exec_ok_i,
  input  logic                      data_ok_i,
  input  logic                      cfg_mismatch_i,
  output pmp_check_pkg::verdict_t   verdict_o
);

  logic                    is_exc;
  logic                    exc_ill;
  logic                    exc_instr_acc;
  logic                    exc_load_acc;
  logic                    exc_store_acc;
  logic                    is_load;
  logic                    is_store;
  pmp_check_pkg::verdict_t verdict_d;
  pmp_check_pkg::verdict_t verdict_q;

  assign is_exc = retire_i.trap.trap && retire_i.trap.exception;

  assign exc_ill       = is_exc && (retire_i.trap.cause == `EXC_ILL_INSTR);
  assign exc_instr_acc = is_exc && (retire_i.trap.cause == `EXC_INSTR_ACC);
  assign exc_load_acc  = is_exc && (retire_i.trap.cause == `EXC_LOAD_ACC);
  assign exc_store_acc = is_exc && (retire_i.trap.cause == `EXC_STORE_ACC);

  assign is_load  = |retire_i.mem_rmask;
  assign is_store = |retire_i.mem_wmask;

  always_comb begin
    verdict_d = '0;
    if (retire_i.valid) begin
      verdict_d.valid    = 1'b1;
      // U-mode must not reach PMP CSRs
      verdict_d.csr_priv = csr_info_i.is_pmp_csr &&
                           (retire_i.mode == `PRIV_U) &&
                           !exc_ill;
      // Denied accesses need the matching access fault
      verdict_d.exec     = !exec_ok_i && !exc_instr_acc;
      verdict_d.load     = is_load && !data_ok_i && !exc_load_acc;
      verdict_d.store    = is_store && !data_ok_i && !exc_store_acc;
      verdict_d.cfg      = csr_info_i.is_cfg0_csrrw && cfg_mismatch_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      verdict_q <= '0;
    end else begin
      verdict_q <= verdict_d;
    end
  end

  assign verdict_o = verdict_q;

endmodule

// ==== hw/pmp_retire_checker.sv ====
`timescale 1ns/1ps

module pmp_retire_checker (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  pmp_check_pkg::retire_t    retire_i,
  input  pmp_check_pkg::pmp_state_t pmp_state_i,
  input  pmp_check_pkg::cfg_write_t cfg_write_i,
  output pmp_check_pkg::verdict_t   verdict_o
);

  pmp_check_pkg::csr_info_t csr_info;
  logic [1:0]               data_priv;
  pmp_check_pkg::pmp_acc_e  data_acc;
  logic                     exec_ok;
  logic                     data_ok;
  logic                     cfg_mismatch;

  pmp_retire_decode u_decode (
    .retire_i    (retire_i),
    .pmp_state_i (pmp_state_i),
    .csr_info_o  (csr_info),
    .data_priv_o (data_priv),
    .data_acc_o  (data_acc)
  );

  // Fetch runs at the retiring privilege
  pmp_region_match u_match_exec (
    .pmp_state_i (pmp_state_i),
    .addr_i      (retire_i.pc),
    .priv_i      (retire_i.mode),
    .acc_i       (pmp_check_pkg::EXEC),
    .allowed_o   (exec_ok)
  );

  pmp_region_match u_match_data (
    .pmp_state_i (pmp_state_i),
    .addr_i      (retire_i.mem_addr),
    .priv_i      (data_priv),
    .acc_i       (data_acc),
    .allowed_o   (data_ok)
  );

  pmp_cfg_legalizer u_legalizer (
    .pmp_state_i    (pmp_state_i),
    .rs1_rdata_i    (retire_i.rs1_rdata),
    .cfg_write_i    (cfg_write_i),
    .cfg_mismatch_o (cfg_mismatch)
  );

  pmp_trap_checker u_trap_checker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .retire_i       (retire_i),
    .csr_info_i     (csr_info),
    .exec_ok_i      (exec_ok),
    .data_ok_i      (data_ok),
    .cfg_mismatch_i (cfg_mismatch),
    .verdict_o      (verdict_o)
  );

endmodule

// ==== dv/pmp_retire_checker_tb.sv ====
`timescale 1ns/1ps
`include "pmp_check_macros.svh"

module pmp_retire_checker_tb;

  localparam int NUM_ROWS      = 15;
  localparam int RESET_CYCLES  = 10;
  localparam int TIMEOUT_LIMIT = NUM_ROWS + RESET_CYCLES + 20;

  localparam logic [31:0] INSN_NOP        = 32'h0000_0013;
  localparam logic [31:0] INSN_CSRRS_3B0  = {12'h3B0, 5'd0, 3'b010, 5'd1, `OPC_SYSTEM};
  localparam logic [31:0] INSN_CSRRW_CFG0 = {`CSR_PMPCFG0, 5'd5, `F3_CSRRW, 5'd0, `OPC_SYSTEM};
  localparam pmp_check_pkg::trap_t NO_TRAP = '0;

  logic                      clk_i;
  logic                      rst_ni;
  pmp_check_pkg::retire_t    retire_drv;
  pmp_check_pkg::pmp_state_t state_drv;
  pmp_check_pkg::cfg_write_t cfg_write_drv;
  pmp_check_pkg::verdict_t   verdict_o;

  string                     row_name [NUM_ROWS];
  pmp_check_pkg::retire_t    row_retire [NUM_ROWS];
  pmp_check_pkg::pmp_state_t row_state [NUM_ROWS];
  pmp_check_pkg::cfg_write_t row_cfg_write [NUM_ROWS];
  pmp_check_pkg::verdict_t   row_expect [NUM_ROWS];
  int                        row_count;
  int                        check_count;
  int                        error_count;
  int                        cycle_count;

  pmp_retire_checker dut0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .retire_i    (retire_drv),
    .pmp_state_i (state_drv),
    .cfg_write_i (cfg_write_drv),
    .verdict_o   (verdict_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_LIMIT) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_LIMIT);
    $display("Some tests failed");
    $finish;
  end

  function automatic pmp_check_pkg::pmpcfg_t cfg_entry(logic lock, pmp_check_pkg::pmp_mode_e mode,
                                                       logic x, logic w, logic r);
    pmp_check_pkg::pmpcfg_t c;
    c      = '0;
    c.lock = lock;
    c.mode = mode;
    c.x    = x;
    c.w    = w;
    c.r    = r;
    return c;
  endfunction

  // TOR data 0..1FFF, NAPOT code 4000..4FFF, NAPOT rw no-exec 8000..8FFF
  function automatic pmp_check_pkg::pmp_state_t base_state();
    pmp_check_pkg::pmp_state_t s;
    s         = '0;
    s.cfg[0]  = cfg_entry(1'b0, pmp_check_pkg::TOR, 1'b0, 1'b0, 1'b1);
    s.addr[0] = 32'h0000_0800;
    s.cfg[1]  = cfg_entry(1'b0, pmp_check_pkg::NAPOT, 1'b1, 1'b0, 1'b1);
    s.addr[1] = 32'h0000_11FF;
    s.cfg[2]  = cfg_entry(1'b0, pmp_check_pkg::NAPOT, 1'b0, 1'b1, 1'b1);
    s.addr[2] = 32'h0000_21FF;
    s.mpp     = `PRIV_U;
    return s;
  endfunction

  function automatic pmp_check_pkg::trap_t exc_trap(logic [5:0] cause);
    return {1'b1, 1'b1, cause};
  endfunction

  function automatic pmp_check_pkg::retire_t retire_record(logic [1:0] mode, logic [31:0] insn,
                                                           pmp_check_pkg::trap_t trap,
                                                           logic [31:0] pc, logic [31:0] mem_addr,
                                                           logic [3:0] rmask, logic [3:0] wmask);
    pmp_check_pkg::retire_t r;
    r.valid     = 1'b1;
    r.insn      = insn;
    r.mode      = mode;
    r.trap      = trap;
    r.rs1_rdata = $urandom();
    r.pc        = pc;
    r.mem_addr  = mem_addr;
    r.mem_rmask = rmask;
    r.mem_wmask = wmask;
    return r;
  endfunction

  function automatic pmp_check_pkg::cfg_write_t random_cfg_write();
    return {$urandom(), $urandom()};
  endfunction

  function automatic pmp_check_pkg::verdict_t flags(logic csr_priv, logic exec, logic load,
                                                    logic store, logic cfg);
    return {1'b1, csr_priv, exec, load, store, cfg};
  endfunction

  // Legal pmpcfg byte for one attempted write
  function automatic logic [7:0] legal_cfg_byte(pmp_check_pkg::pmpcfg_t old_cfg,
                                                logic [7:0] attempt_byte);
    pmp_check_pkg::pmpcfg_t result;
    result = attempt_byte;
    if (result.w && !result.r) begin
      result.x = old_cfg.x;
      result.w = old_cfg.w;
      result.r = old_cfg.r;
    end
    if (old_cfg.lock) begin
      result = old_cfg;
    end
    result.zero = 2'b00;
    return result;
  endfunction

  function automatic logic [31:0] legalize_cfg0(pmp_check_pkg::pmp_state_t s, logic [31:0] rs1);
    logic [31:0] word;
    for (int i = 0; i < 4; i++) begin
      word[i*8 +: 8] = legal_cfg_byte(s.cfg[i], rs1[i*8 +: 8]);
    end
    return word;
  endfunction

  task automatic add_row(string name, pmp_check_pkg::retire_t r, pmp_check_pkg::pmp_state_t s,
                         pmp_check_pkg::cfg_write_t w, pmp_check_pkg::verdict_t e);
    row_name[row_count]      = name;
    row_retire[row_count]    = r;
    row_state[row_count]     = s;
    row_cfg_write[row_count] = w;
    row_expect[row_count]    = e;
    row_count++;
  endtask

  task automatic build_table();
    pmp_check_pkg::pmp_state_t base;
    pmp_check_pkg::pmp_state_t locked;
    pmp_check_pkg::pmp_state_t mprv_u;
    pmp_check_pkg::retire_t    r;
    pmp_check_pkg::cfg_write_t w;
    base               = base_state();
    locked             = base;
    locked.cfg[1].lock = 1'b1;
    mprv_u             = base;
    mprv_u.mprv        = 1'b1;

    r = retire_record(`PRIV_U, INSN_CSRRS_3B0, exc_trap(`EXC_ILL_INSTR), 32'h4000,
                      $urandom(), 0, 0);
    add_row("csr_u_trapped", r, base, random_cfg_write(), flags(0, 0, 0, 0, 0));
    r.trap = NO_TRAP;
    add_row("csr_u_untrapped", r, base, random_cfg_write(), flags(1, 0, 0, 0, 0));

    // Fetch from the no-exec NAPOT region
    r = retire_record(`PRIV_U, INSN_NOP, NO_TRAP, 32'h8010, $urandom(), 0, 0);
    add_row("fetch_u_noexec", r, base, random_cfg_write(), flags(0, 1, 0, 0, 0));
    r.trap = exc_trap(`EXC_INSTR_ACC);
    add_row("fetch_u_noexec_trap", r, base, random_cfg_write(), flags(0, 0, 0, 0, 0));
    r = retire_record(`PRIV_M, INSN_NOP, NO_TRAP, 32'h8010, $urandom(), 0, 0);
    add_row("fetch_m_unlocked", r, base, random_cfg_write(), flags(0, 0, 0, 0, 0));

    // Read-only TOR region
    r = retire_record(`PRIV_U, INSN_NOP, NO_TRAP, 32'h4000, 32'h0000_0100, 4'hF, 4'h0);
    add_row("load_tor_ok", r, base, random_cfg_write(), flags(0, 0, 0, 0, 0));
    r = retire_record(`PRIV_U, INSN_NOP, NO_TRAP, 32'h4004, 32'h0000_0100, 4'h0, 4'hF);
    add_row("store_tor_denied", r, base, random_cfg_write(), flags(0, 0, 0, 1, 0));
    r.trap = exc_trap(`EXC_STORE_ACC);
    add_row("store_tor_trapped", r, base, random_cfg_write(), flags(0, 0, 0, 0, 0));
    r = retire_record(`PRIV_U, INSN_NOP, NO_TRAP, 32'h4008, 32'h0001_0000, 4'h3, 4'h0);
    add_row("load_u_nomatch", r, base, random_cfg_write(), flags(0, 0, 1, 0, 0));
    r = retire_record(`PRIV_M, INSN_NOP, NO_TRAP, 32'h4008, 32'h0001_0000, 4'hF, 4'h0);
    add_row("load_mprv_mpp_u", r, mprv_u, random_cfg_write(), flags(0, 0, 1, 0, 0));

    // csrrw to pmpcfg0
    r = retire_record(`PRIV_M, INSN_CSRRW_CFG0, NO_TRAP, 32'h4010, $urandom(), 0, 0);
    r.rs1_rdata = 32'h000A_6F19;
    w.wdata = legalize_cfg0(base, r.rs1_rdata);
    w.wmask = '1;
    add_row("cfg_legal", r, base, w, flags(0, 0, 0, 0, 0));
    r.rs1_rdata = 32'h0000_0F00;
    w.wdata = legalize_cfg0(locked, r.rs1_rdata);
    w.wdata[1] = 8'h0F;
    add_row("cfg_locked_attempt", r, locked, w, flags(0, 0, 0, 0, 1));
    r.rs1_rdata = 32'h0000_000A;
    w.wdata = r.rs1_rdata;
    add_row("cfg_w_without_r", r, base, w, flags(0, 0, 0, 0, 1));
    r.rs1_rdata = 32'h000A_6F19;
    w.wdata = legalize_cfg0(base, r.rs1_rdata);
    w.wmask = 32'hFF0F_FFFF;
    add_row("cfg_partial_mask", r, base, w, flags(0, 0, 0, 0, 1));

    r = retire_record(`PRIV_U, $urandom(), exc_trap(6'($urandom())), $urandom(),
                      $urandom(), 4'hF, 4'hF);
    r.valid = 1'b0;
    add_row("idle", r, base, random_cfg_write(), '0);
  endtask

  task automatic check_verdict(string name, pmp_check_pkg::verdict_t expected);
    check_count++;
    if (verdict_o !== expected) begin
      error_count++;
      $display("ERROR %s: expected %b, actual %b", name, expected, verdict_o);
    end
  endtask

  initial begin
    void'($urandom(15));
    rst_ni        = 1'b0;
    retire_drv    = '0;
    state_drv     = '0;
    cfg_write_drv = '0;
    row_count     = 0;
    check_count   = 0;
    error_count   = 0;
    build_table();

    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_verdict("after_reset", '0);

    // Verdict of row i-1 is checked while row i is driven
    for (int i = 0; i < NUM_ROWS; i++) begin
      @(posedge clk_i);
      #1;
      if (i > 0) begin
        check_verdict(row_name[i-1], row_expect[i-1]);
      end
      retire_drv    = row_retire[i];
      state_drv     = row_state[i];
      cfg_write_drv = row_cfg_write[i];
    end
    @(posedge clk_i);
    #1;
    check_verdict(row_name[NUM_ROWS-1], row_expect[NUM_ROWS-1]);

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+hw
hw/pmp_check_pkg.sv
hw/pmp_retire_decode.sv
hw/pmp_region_match.sv
hw/pmp_cfg_legalizer.sv
hw/pmp_trap_checker.sv
hw/pmp_retire_checker.sv
dv/pmp_retire_checker_tb.sv
